// ==== logic/sdram_consts.svh ====
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// SDRAM geometry, word addressed (bank, row, column from the top bit)
`define SDR_ROW_W   13
`define SDR_COL_W   9
`define SDR_BANK_W  2
`define SDR_WADDR_W (`SDR_BANK_W + `SDR_ROW_W + `SDR_COL_W)

// CPU side is byte addressed, one bit wider than the word address
`define CPU_ADDR_W  25

// Power-up wait before the first precharge-all, shortened so simulation stays quick
`define SDR_INIT_CYCLES 200

// Device timing in i_sysclk cycles
`define SDR_TRP  2      // Precharge to next command
`define SDR_TRCD 2      // ACTIVE to READ or WRITE
`define SDR_TRFC 7      // REFRESH to next command

// Read latency programmed into the mode register
`define SDR_CAS_LAT 2

// Cycles between periodic auto refreshes
`define SDR_REFRESH_CYCLES 780

`endif

// ==== logic/sdram_pkg.sv ====
`include "sdram_consts.svh"

package sdram_pkg;

    // One word address, seen either as a flat index or split into its fields
    typedef union packed {
        logic [`SDR_WADDR_W-1:0] flat;          // Word index as the adapter builds it
        struct packed {
            logic [`SDR_BANK_W-1:0] bank;       // Top bits select the bank
            logic [`SDR_ROW_W-1:0]  row;        // Opened by ACTIVE
            logic [`SDR_COL_W-1:0]  col;        // Given with READ or WRITE
        } brc;
    } sdr_addr_u;

    // Command lines as {n_cs, n_ras, n_cas, n_we}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b1111     // Chip deselected, the device sees no command
    } sdr_cmd_e;

endpackage

// ==== logic/sdram_controller.sv ====
`include "sdram_consts.svh"

module sdram_controller (
    input  logic                   i_sysclk,
    input  logic                   i_arst,
    input  logic                   i_we,           // Write request, held until o_wr_ack
    input  logic                   i_re,           // Read request, held until o_rd_ack
    input  sdram_pkg::sdr_addr_u   i_addr,         // Word address, read through its fields
    input  logic [15:0]            i_din,
    input  logic [1:0]             i_dm,           // High bit masks the upper byte
    input  logic [15:0]            i_sdr_data,     // DQ coming back from the device
    output logic [15:0]            o_dout,
    output logic                   o_init_done,
    output logic                   o_wr_ack,
    output logic                   o_rd_ack,
    output logic                   o_rd_valid,
    output logic                   o_refreshing,
    output logic                   o_sdr_cke,
    output logic                   o_sdr_n_cs,
    output logic                   o_sdr_n_ras,
    output logic                   o_sdr_n_cas,
    output logic                   o_sdr_n_we,
    output logic [`SDR_BANK_W-1:0] o_sdr_ba,
    output logic [`SDR_ROW_W-1:0]  o_sdr_addr,
    output logic [15:0]            o_sdr_data,
    output logic                   o_sdr_data_oe,
    output logic [1:0]             o_sdr_dqm
);

    localparam logic [3:0] ST_INIT_WAIT = 4'd0;    // Power-up delay with CKE high
    localparam logic [3:0] ST_INIT_PRE  = 4'd1;
    localparam logic [3:0] ST_INIT_REF1 = 4'd2;
    localparam logic [3:0] ST_INIT_REF2 = 4'd3;
    localparam logic [3:0] ST_INIT_MODE = 4'd4;
    localparam logic [3:0] ST_IDLE      = 4'd5;
    localparam logic [3:0] ST_REFRESH   = 4'd6;
    localparam logic [3:0] ST_ACTIVE    = 4'd7;    // Row open, waiting out tRCD
    localparam logic [3:0] ST_RW        = 4'd8;    // Column command is on the pins
    localparam logic [3:0] ST_CAS_WAIT  = 4'd9;
    localparam logic [3:0] ST_PRE_WAIT  = 4'd10;   // Auto precharge in progress

    localparam int CNT_W = $clog2(`SDR_INIT_CYCLES);
    localparam int REF_W = $clog2(`SDR_REFRESH_CYCLES);
    localparam int CAS_W = `SDR_CAS_LAT;

    logic [3:0]          r_state;
    logic [CNT_W-1:0]    r_cnt;           // Shared wait counter, counts down to zero
    logic                w_cnt_done;
    logic                r_is_wr;         // Direction of the access in flight
    sdram_pkg::sdr_cmd_e r_cmd;
    logic [REF_W-1:0]    r_ref_cnt;
    logic                r_ref_pending;
    logic                w_ref_start;
    logic [CAS_W-1:0]    r_rd_pipe;       // Tracks a READ until its data reaches DQ

    assign w_cnt_done  = (r_cnt == '0);
    assign w_ref_start = (r_state == ST_IDLE) && r_ref_pending;    // Refresh beats a request

    assign {o_sdr_n_cs, o_sdr_n_ras, o_sdr_n_cas, o_sdr_n_we} = r_cmd;

    // Interval timer, only running once the device is ready
    always_ff @(posedge i_sysclk or posedge i_arst) begin
        if (i_arst) begin
            r_ref_cnt     <= REF_W'(`SDR_REFRESH_CYCLES - 1);
            r_ref_pending <= 1'b0;
        end else if (o_init_done) begin
            if (w_ref_start)
                r_ref_pending <= 1'b0;                 // Taken by the FSM this cycle
            if (r_ref_cnt == '0) begin
                r_ref_cnt     <= REF_W'(`SDR_REFRESH_CYCLES - 1);
                r_ref_pending <= 1'b1;
            end else begin
                r_ref_cnt <= r_ref_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge i_sysclk or posedge i_arst) begin
        if (i_arst) begin
            r_state       <= ST_INIT_WAIT;
            r_cnt         <= CNT_W'(`SDR_INIT_CYCLES - 1);
            r_is_wr       <= 1'b0;
            r_cmd         <= sdram_pkg::CMD_NOP;
            o_sdr_cke     <= 1'b0;
            o_sdr_ba      <= '0;
            o_sdr_addr    <= '0;
            o_sdr_data    <= '0;
            o_sdr_data_oe <= 1'b0;
            o_sdr_dqm     <= 2'b00;
            o_init_done   <= 1'b0;
            o_refreshing  <= 1'b0;
            o_wr_ack      <= 1'b0;
            o_rd_ack      <= 1'b0;
        end else begin
            // Anything not issued below is a one-cycle NOP
            r_cmd         <= sdram_pkg::CMD_NOP;
            o_sdr_data_oe <= 1'b0;
            o_sdr_dqm     <= 2'b00;
            o_wr_ack      <= 1'b0;
            o_rd_ack      <= 1'b0;
            if (!w_cnt_done)
                r_cnt <= r_cnt - 1'b1;

            case (r_state)
                ST_INIT_WAIT: begin
                    o_sdr_cke <= 1'b1;                  // Clock enable comes up right away
                    if (w_cnt_done) begin
                        r_cmd          <= sdram_pkg::CMD_PRECHARGE;
                        o_sdr_addr     <= '0;
                        o_sdr_addr[10] <= 1'b1;         // A10 high closes all banks
                        r_cnt          <= CNT_W'(`SDR_TRP - 1);
                        r_state        <= ST_INIT_PRE;
                    end
                end
                ST_INIT_PRE, ST_INIT_REF1: begin
                    if (w_cnt_done) begin
                        r_cmd   <= sdram_pkg::CMD_REFRESH;
                        r_cnt   <= CNT_W'(`SDR_TRFC - 1);
                        r_state <= (r_state == ST_INIT_PRE) ? ST_INIT_REF1 : ST_INIT_REF2;
                    end
                end
                ST_INIT_REF2: begin
                    if (w_cnt_done) begin
                        // Burst length one, sequential, CAS latency in bits 6:4
                        r_cmd           <= sdram_pkg::CMD_LOAD_MODE;
                        o_sdr_ba        <= '0;
                        o_sdr_addr      <= '0;
                        o_sdr_addr[6:4] <= 3'(`SDR_CAS_LAT);
                        r_cnt           <= CNT_W'(`SDR_TRP - 1);    // Covers tMRD
                        r_state         <= ST_INIT_MODE;
                    end
                end
                ST_INIT_MODE: begin
                    if (w_cnt_done) begin
                        o_init_done <= 1'b1;
                        r_state     <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (w_ref_start) begin
                        // Every bank is already closed by auto precharge
                        r_cmd        <= sdram_pkg::CMD_REFRESH;
                        o_refreshing <= 1'b1;
                        r_cnt        <= CNT_W'(`SDR_TRFC - 1);
                        r_state      <= ST_REFRESH;
                    end else if (i_we || i_re) begin
                        r_cmd      <= sdram_pkg::CMD_ACTIVE;
                        o_sdr_ba   <= i_addr.brc.bank;
                        o_sdr_addr <= i_addr.brc.row;
                        r_is_wr    <= i_we;
                        r_cnt      <= CNT_W'(`SDR_TRCD - 1);
                        r_state    <= ST_ACTIVE;
                    end
                end
                ST_REFRESH: begin
                    if (w_cnt_done) begin
                        o_refreshing <= 1'b0;
                        r_state      <= ST_IDLE;
                    end
                end
                ST_ACTIVE: begin
                    if (w_cnt_done) begin
                        // Column command with auto precharge, bank kept from ACTIVE
                        r_cmd <= r_is_wr ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
                        o_sdr_addr                 <= '0;
                        o_sdr_addr[`SDR_COL_W-1:0] <= i_addr.brc.col;
                        o_sdr_addr[10]             <= 1'b1;
                        if (r_is_wr) begin
                            o_sdr_data    <= i_din;
                            o_sdr_data_oe <= 1'b1;
                            o_sdr_dqm     <= i_dm;      // Write mask applies with zero latency
                            o_wr_ack      <= 1'b1;
                        end else begin
                            o_rd_ack <= 1'b1;
                        end
                        r_state <= ST_RW;
                    end
                end
                ST_RW: begin
                    r_cnt   <= CNT_W'(`SDR_CAS_LAT - 1);
                    r_state <= ST_CAS_WAIT;
                end
                ST_CAS_WAIT: begin
                    if (w_cnt_done) begin
                        r_cnt   <= CNT_W'(`SDR_TRP - 1);
                        r_state <= ST_PRE_WAIT;
                    end
                end
                ST_PRE_WAIT: begin
                    if (w_cnt_done)
                        r_state <= ST_IDLE;
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    // The read ack marks the READ cycle, data is sampled CAS clocks after the device took it
    always_ff @(posedge i_sysclk or posedge i_arst) begin
        if (i_arst) begin
            r_rd_pipe  <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            r_rd_pipe  <= (r_rd_pipe << 1) | CAS_W'(o_rd_ack);
            o_rd_valid <= r_rd_pipe[CAS_W-1];
        end
    end

    always_ff @(posedge i_sysclk) begin
        if (r_rd_pipe[CAS_W-1])
            o_dout <= i_sdr_data;           // Held until the next read returns
    end

endmodule

// ==== logic/sdram_adapter.sv ====
`include "sdram_consts.svh"

module sdram_adapter (
    input  logic                   i_sysclk,
    input  logic                   i_arst,
    input  logic                   i_cpuclk,       // phi2 level, sampled on i_sysclk
    input  logic                   i_cs,
    input  logic                   i_rwb,          // Low for a write
    input  logic [`CPU_ADDR_W-1:0] i_addr,         // Byte address
    input  logic [7:0]             i_data,
    input  logic [15:0]            i_sdr_data,
    output logic [7:0]             o_data,
    output logic                   o_wait,         // Asks the CPU to stretch phi2
    output logic                   o_sdr_init_done,
    output logic                   o_sdr_cke,
    output logic                   o_sdr_n_cs,
    output logic                   o_sdr_n_ras,
    output logic                   o_sdr_n_cas,
    output logic                   o_sdr_n_we,
    output logic [1:0]             o_sdr_ba,
    output logic [12:0]            o_sdr_addr,
    output logic [15:0]            o_sdr_data,
    output logic                   o_sdr_data_oe,
    output logic [1:0]             o_sdr_dqm
);

    localparam logic [1:0] ST_WAIT    = 2'd0;      // Idle between CPU cycles
    localparam logic [1:0] ST_ACCESS  = 2'd1;      // Write selected, waiting for phi2 low
    localparam logic [1:0] ST_WR_PEND = 2'd2;
    localparam logic [1:0] ST_RD_PEND = 2'd3;

    logic [1:0]           r_state;
    logic                 r_we;          // Requests to the controller
    logic                 r_re;
    logic                 r_done;        // Ack or data seen for the current cycle
    sdram_pkg::sdr_addr_u r_addr;
    logic                 r_lane;        // Byte address bit 0, picks the half of the word
    logic [7:0]           r_wdata;
    logic [1:0]           r_dm;
    logic                 w_rd_start;
    logic                 w_wr_start;
    logic [15:0]          w_dout;
    logic                 w_wr_ack;
    logic                 w_rd_ack;
    logic                 w_rd_valid;
    logic                 w_refreshing;

    // Reads go out on the first selected high sample, the address is already stable
    assign w_rd_start = (r_state == ST_WAIT) && o_sdr_init_done && i_cs && i_cpuclk && i_rwb;
    // Write data is only trusted once phi2 has fallen
    assign w_wr_start = (r_state == ST_ACCESS) && !i_cpuclk;

    always_ff @(posedge i_sysclk or posedge i_arst) begin
        if (i_arst) begin
            r_state <= ST_WAIT;
            r_we    <= 1'b0;
            r_re    <= 1'b0;
            r_done  <= 1'b0;
        end else begin
            case (r_state)
                ST_WAIT: begin
                    r_done <= 1'b0;
                    if (w_rd_start) begin
                        r_re    <= 1'b1;
                        r_state <= ST_RD_PEND;
                    end else if (o_sdr_init_done && i_cs && i_cpuclk && !i_rwb) begin
                        r_state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (w_wr_start) begin
                        r_we    <= 1'b1;
                        r_state <= ST_WR_PEND;
                    end
                end
                ST_WR_PEND: begin
                    if (w_wr_ack) begin
                        r_we   <= 1'b0;         // Request drops the cycle after the ack
                        r_done <= 1'b1;
                    end
                    if (r_done && !i_cpuclk)
                        r_state <= ST_WAIT;
                end
                ST_RD_PEND: begin
                    if (w_rd_ack)
                        r_re <= 1'b0;
                    if (w_rd_valid)
                        r_done <= 1'b1;
                    // A read that ran long still waits for the low phase before rearming
                    if (r_done && !i_cpuclk)
                        r_state <= ST_WAIT;
                end
                default: r_state <= ST_WAIT;
            endcase
        end
    end

    always_ff @(posedge i_sysclk) begin
        if (w_rd_start || w_wr_start) begin
            r_addr.flat <= i_addr[`CPU_ADDR_W-1:1];      // Byte address halved to a word
            r_lane      <= i_addr[0];
            r_wdata     <= i_data;
            r_dm        <= i_addr[0] ? 2'b01 : 2'b10;    // Only the addressed lane is written
        end
        if ((r_state == ST_RD_PEND) && w_rd_valid)
            o_data <= r_lane ? w_dout[15:8] : w_dout[7:0];
    end

    // Wait follows the refresh, then is released on a low phase so phi2 restarts cleanly
    always_ff @(posedge i_sysclk or posedge i_arst) begin
        if (i_arst)
            o_wait <= 1'b0;
        else if (w_refreshing)
            o_wait <= 1'b1;
        else if (!i_cpuclk)
            o_wait <= 1'b0;
    end

    sdram_controller u_sdram_controller (
        .i_sysclk      (i_sysclk),
        .i_arst        (i_arst),
        .i_we          (r_we),
        .i_re          (r_re),
        .i_addr        (r_addr),
        .i_din         ({r_wdata, r_wdata}),     // Byte copied to both halves, mask picks one
        .i_dm          (r_dm),
        .i_sdr_data    (i_sdr_data),
        .o_dout        (w_dout),
        .o_init_done   (o_sdr_init_done),
        .o_wr_ack      (w_wr_ack),
        .o_rd_ack      (w_rd_ack),
        .o_rd_valid    (w_rd_valid),
        .o_refreshing  (w_refreshing),
        .o_sdr_cke     (o_sdr_cke),
        .o_sdr_n_cs    (o_sdr_n_cs),
        .o_sdr_n_ras   (o_sdr_n_ras),
        .o_sdr_n_cas   (o_sdr_n_cas),
        .o_sdr_n_we    (o_sdr_n_we),
        .o_sdr_ba      (o_sdr_ba),
        .o_sdr_addr    (o_sdr_addr),
        .o_sdr_data    (o_sdr_data),
        .o_sdr_data_oe (o_sdr_data_oe),
        .o_sdr_dqm     (o_sdr_dqm)
    );

endmodule

// ==== testbench/sdram_model.sv ====
`include "sdram_consts.svh"

module sdram_model (
    input  logic                   i_clk,
    input  logic                   i_cke,
    input  logic [3:0]             i_cmd,          // {n_cs, n_ras, n_cas, n_we}
    input  logic [`SDR_BANK_W-1:0] i_ba,
    input  logic [`SDR_ROW_W-1:0]  i_addr,
    input  logic [15:0]            i_dq,
    input  logic                   i_dq_oe,
    input  logic [1:0]             i_dqm,          // High bit masks the upper byte
    output logic [15:0]            o_dq
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0]           mem [int];              // Sparse store keyed by the flat word index
    logic [`SDR_ROW_W-1:0] open_row [4];
    logic [15:0]           rd_pipe [`SDR_CAS_LAT];  // Read data walks through CAS latency
    sdram_pkg::sdr_cmd_e   cmd;
    sdram_pkg::sdr_addr_u  waddr;
    int                    cycle = 0;
    int                    last_active = -100;
    int                    last_refresh = -100;
    int                    refresh_count = 0;      // Includes the two init refreshes
    int                    read_count = 0;
    int                    timing_errors = 0;
    int                    mode_cas = 0;
    bit                    saw_prech_all = 0;

    assign cmd  = sdram_pkg::sdr_cmd_e'(i_cmd);
    assign o_dq = rd_pipe[`SDR_CAS_LAT-1];         // Valid at the edge CAS clocks after READ

    always @(posedge i_clk) begin : decode
        logic [15:0] word;
        for (int i = `SDR_CAS_LAT - 1; i > 0; i--)
            rd_pipe[i] <= rd_pipe[i-1];
        rd_pipe[0] <= 16'h0000;
        if (i_cke && cmd != sdram_pkg::CMD_NOP) begin
            // Nothing may start while a refresh is still running
            assert (cycle - last_refresh >= `SDR_TRFC) else begin
                $display("Error: %0t %s issued %0d cycles after REFRESH", $time, cmd.name(),
                         cycle - last_refresh);
                timing_errors++;
            end
            case (cmd)
                sdram_pkg::CMD_ACTIVE: begin
                    open_row[i_ba] = i_addr;
                    last_active    = cycle;
                end
                sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
                    assert (cycle - last_active >= `SDR_TRCD) else begin
                        $display("Error: %0t %s only %0d cycles after ACTIVE", $time,
                                 cmd.name(), cycle - last_active);
                        timing_errors++;
                    end
                    waddr.brc.bank = i_ba;
                    waddr.brc.row  = open_row[i_ba];
                    waddr.brc.col  = i_addr[`SDR_COL_W-1:0];
                    word = mem.exists(int'(waddr.flat)) ? mem[int'(waddr.flat)] : 16'h0000;
                    if (cmd == sdram_pkg::CMD_WRITE) begin
                        if (!i_dq_oe) begin
                            $display("Error: %0t WRITE without DQ driven", $time);
                            timing_errors++;
                        end
                        if (!i_dqm[0])
                            word[7:0] = i_dq[7:0];
                        if (!i_dqm[1])
                            word[15:8] = i_dq[15:8];   // Masked half keeps its old byte
                        mem[int'(waddr.flat)] = word;
                    end else begin
                        rd_pipe[0] <= word;
                        read_count++;
                    end
                end
                sdram_pkg::CMD_PRECHARGE: begin
                    if (i_addr[10])
                        saw_prech_all = 1'b1;
                end
                sdram_pkg::CMD_REFRESH: begin
                    refresh_count++;
                    last_refresh = cycle;
                end
                sdram_pkg::CMD_LOAD_MODE: mode_cas = {29'd0, i_addr[6:4]};
                default: ;
            endcase
        end
        cycle++;
    end

endmodule

// ==== testbench/tb_sdram_adapter.sv ====
`include "sdram_consts.svh"

module tb_sdram_adapter;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 2000;                 // Clock limit for every wait loop

    logic        sysclk;
    logic        arst;
    logic        cpuclk;                           // phi2 level seen by the adapter
    logic        cs;
    logic        rwb;
    logic [24:0] addr;
    logic [7:0]  wdata;
    logic [15:0] dq_in;
    logic [7:0]  rdata;
    logic        wait_req;
    logic        init_done;
    logic        cke;
    logic        n_cs;
    logic        n_ras;
    logic        n_cas;
    logic        n_we;
    logic [1:0]  ba;
    logic [12:0] sdr_addr;
    logic [15:0] dq_out;
    logic        dq_oe;
    logic [1:0]  dqm;
    logic [31:0] lfsr = 32'h6757;
    logic [7:0]  shadow [int];                     // Expected byte contents
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    bit          wait_seen = 0;                    // Set once o_wait has been high

    sdram_adapter dut (
        .i_sysclk(sysclk), .i_arst(arst), .i_cpuclk(cpuclk), .i_cs(cs), .i_rwb(rwb),
        .i_addr(addr), .i_data(wdata), .i_sdr_data(dq_in), .o_data(rdata),
        .o_wait(wait_req), .o_sdr_init_done(init_done), .o_sdr_cke(cke),
        .o_sdr_n_cs(n_cs), .o_sdr_n_ras(n_ras), .o_sdr_n_cas(n_cas), .o_sdr_n_we(n_we),
        .o_sdr_ba(ba), .o_sdr_addr(sdr_addr), .o_sdr_data(dq_out),
        .o_sdr_data_oe(dq_oe), .o_sdr_dqm(dqm)
    );

    sdram_model u_model (
        .i_clk(sysclk), .i_cke(cke), .i_cmd({n_cs, n_ras, n_cas, n_we}), .i_ba(ba),
        .i_addr(sdr_addr), .i_dq(dq_out), .i_dq_oe(dq_oe), .i_dqm(dqm), .o_dq(dq_in)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;              // 20 ns period
    end

    // DQ is only driven along with a WRITE command
    assert property (@(posedge sysclk) disable iff (arst)
        dq_oe |-> ({n_cs, n_ras, n_cas, n_we} == sdram_pkg::CMD_WRITE))
        else begin
            $display("Error: %0t DQ output enable high without a WRITE command", $time);
            errors++;
        end
    assert property (@(posedge sysclk) disable iff (arst) !init_done |-> !wait_req)
        else begin
            $display("Error: %0t o_wait high before init finished", $time);
            errors++;
        end

    always @(posedge sysclk)
        if (wait_req)
            wait_seen <= 1'b1;

    // Galois LFSR stepped once for every bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};             // Output bit comes off the bottom
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("Error: %0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic timeout_fail(string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic report_test(string name, int errors_before);
        tests++;
        $display("Test %0d %s %s", tests, name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    // Drives one phi2 cycle of 8 clocks high and 8 low and stretches the low phase on o_wait
    task automatic bus_cycle(logic is_read, logic [24:0] a, logic [7:0] d);
        int n;
        @(posedge sysclk);
        cs     <= 1'b1;
        rwb    <= is_read;
        addr   <= a;
        wdata  <= d;
        cpuclk <= 1'b1;
        repeat (8) @(posedge sysclk);
        cpuclk <= 1'b0;                        // Write data is taken from here on
        repeat (8) @(posedge sysclk);
        n = 0;
        @(negedge sysclk);
        while (wait_req && n < TIMEOUT) begin
            @(negedge sysclk);
            n++;
        end
        if (n >= TIMEOUT)
            timeout_fail("o_wait to fall");
    endtask

    // Deselects the adapter and leaves it time to finish and rearm
    task automatic bus_idle();
        @(posedge sysclk);
        cs <= 1'b0;
        repeat (8) @(posedge sysclk);
    endtask

    task automatic write_byte(logic [24:0] a, logic [7:0] d);
        bus_cycle(1'b0, a, d);
        bus_idle();
        shadow[int'(a)] = d;
    endtask

    task automatic read_check(logic [24:0] a);
        int reads_before;
        reads_before = u_model.read_count;
        bus_cycle(1'b1, a, 8'h00);
        // The read has to be complete by the end of the phi2 cycle
        check_val("model READ count", reads_before + 1, u_model.read_count);
        if (shadow.exists(int'(a)))            // Unwritten bytes have no expected value
            check_val("o_data", {24'd0, shadow[int'(a)]}, {24'd0, rdata});
        bus_idle();
    endtask

    function automatic logic [24:0] make_addr(logic [1:0] b, logic [12:0] r, logic [8:0] c);
        return {b, r, c, 1'b0};                // Bank, row, column, then the byte lane
    endfunction

    initial begin
        int          n;
        int          e0;
        int          t0;
        int          refs0;
        logic [24:0] a;
        logic [24:0] list [$];
        arst   = 1'b1;
        cpuclk = 1'b0;
        cs     = 1'b0;
        rwb    = 1'b1;
        addr   = '0;
        wdata  = '0;

        e0 = errors;
        @(posedge sysclk);
        @(negedge sysclk);
        check_val("o_wait", 0, wait_req);
        check_val("o_sdr_init_done", 0, init_done);
        check_val("o_sdr_cke", 0, cke);
        @(posedge sysclk);
        arst <= 1'b0;                          // Second rising edge still sees reset
        @(negedge sysclk);
        check_val("o_wait", 0, wait_req);
        check_val("o_sdr_init_done", 0, init_done);
        check_val("o_sdr_cke", 0, cke);
        n = 0;
        while (!init_done && n < TIMEOUT) begin
            @(negedge sysclk);
            n++;
        end
        if (n >= TIMEOUT)
            timeout_fail("o_sdr_init_done");
        check_val("precharge-all seen", 1, u_model.saw_prech_all);
        check_val("init refreshes", 2, u_model.refresh_count);
        check_val("mode CAS latency", `SDR_CAS_LAT, u_model.mode_cas);
        report_test("reset and init", e0);

        e0 = errors;
        write_byte(25'h00_00A4, 8'h5A);
        write_byte(25'h00_00A5, 8'hC3);        // Odd lane of the same word
        read_check(25'h00_00A4);
        read_check(25'h00_00A5);
        report_test("byte lanes", e0);

        e0 = errors;
        for (int b = 0; b < 4; b++)
            list.push_back(make_addr(2'(b), 13'd5, 9'd7));
        for (int r = 1; r < 4; r++)
            list.push_back(make_addr(2'd1, 13'(r * 100), 9'd7));
        for (int c = 1; c < 4; c++)
            list.push_back(make_addr(2'd1, 13'd5, 9'(c * 31)));
        foreach (list[i])
            write_byte(list[i], 8'(8'h20 + i));
        foreach (list[i])
            read_check(list[i]);
        report_test("banks and rows", e0);

        e0 = errors;
        t0     = u_model.cycle;
        refs0  = u_model.refresh_count;
        wait_seen = 1'b0;
        // Random traffic spanning more than three refresh intervals
        while (u_model.cycle - t0 < 3 * `SDR_REFRESH_CYCLES + 200) begin
            a = 25'h01F_0000 | 25'(rand_bits(6));
            if (rand_bits(1) == 1)
                write_byte(a, 8'(rand_bits(8)));
            else
                read_check(a);
        end
        check_val("refreshes in window",
                  1, (u_model.refresh_count - refs0 >=
                      (u_model.cycle - t0) / (`SDR_REFRESH_CYCLES + `SDR_TRFC + 26)) ? 1 : 0);
        check_val("o_wait seen high", 1, wait_seen);
        report_test("refresh and wait", e0);

        e0 = errors;
        for (int i = 0; i < 64; i++) begin
            write_byte(25'h002_0000 | 25'(rand_bits(6)), 8'(rand_bits(8)));
            read_check(25'h002_0000 | 25'(rand_bits(6)));
        end
        report_test("random traffic", e0);

        e0 = errors;
        check_val("model timing errors", 0, u_model.timing_errors);
        report_test("timing", e0);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/sdram_pkg.sv
logic/sdram_controller.sv
logic/sdram_adapter.sv
testbench/sdram_model.sv
testbench/tb_sdram_adapter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_sdram_adapter -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
